/* source/spiBusPkg.sv */
/*
 * SPI block bus-side definitions
 * Register bus data width and the CSR offset map
 */
`default_nettype none

package spiBusPkg;

	//--------------------------------------------------------------------
	// Register bus
	//--------------------------------------------------------------------
	localparam int busDataWidth   = 32;	// Usi data width
	localparam int csrOffsetWidth = 8;	// Low address field inside block

	//--------------------------------------------------------------------
	// CSR offsets
	//--------------------------------------------------------------------
	localparam logic [csrOffsetWidth-1:0] csrEnOffset     = 8'h00;	// Bit 0 enable
	localparam logic [csrOffsetWidth-1:0] csrDivOffset    = 8'h04;	// SCK divider
	localparam logic [csrOffsetWidth-1:0] csrTxOffset     = 8'h08;	// Write starts xfer
	localparam logic [csrOffsetWidth-1:0] csrCsOffset     = 8'h0C;	// 1 = chip selected
	localparam logic [csrOffsetWidth-1:0] csrRxOffset     = 8'h10;	// Last rx byte, RO
	localparam logic [csrOffsetWidth-1:0] csrStatusOffset = 8'h14;	// Bit 0 busy, RO

endpackage

`default_nettype wire

/* source/spiCorePkg.sv */
/*
 * SPI engine definitions
 * Divider, byte and bit counter widths
 */
`default_nettype none

package spiCorePkg;

	//--------------------------------------------------------------------
	// Shift engine sizing
	//--------------------------------------------------------------------
	localparam int divWidth      = 16;	// Half-period reload value
	localparam int spiByteWidth  = 8;	// One transfer
	localparam int bitCountWidth = 3;	// Counts 0..7 within a byte

	// Half-period count is spiDiv+1 sysClk cycles, so a full byte
	// spans 2*spiByteWidth half periods

endpackage

`default_nettype wire

/* source/spiCsr.sv */
/*
 * SPI CSR block
 * Decodes Usi accesses for this block, holds the control registers,
 * issues the transfer start pulse and returns registered read data
 */
`timescale 1ns/10ps
`default_nettype none

module spiCsr
	import spiBusPkg::*;
	import spiCorePkg::*;
#(
	parameter int                        busAdrsWidth   = 16,
	parameter int                        blockAdrsWidth = 8,
	parameter logic [blockAdrsWidth-1:0] blockAdrs      = 8'h03
)(
	// Usi slave write
	input  wire logic [busDataWidth-1:0] usiWd,
	input  wire logic [busAdrsWidth-1:0] usiAdrs,
	input  wire logic                    usiWCke,
	// Usi slave read
	input  wire logic                    usiRCke,
	output      logic [busDataWidth-1:0] usiRd,
	output      logic                    usiREd,
	// Control towards the master unit
	output      logic                    spiEn,
	output      logic [divWidth-1:0]     spiDiv,
	output      logic [spiByteWidth-1:0] txByte,
	output      logic                    csLevel,
	output      logic                    txStart,
	// Status from the master unit
	input  wire logic [spiByteWidth-1:0] rxByte,
	input  wire logic                    busy,
	// Clock and reset
	input  wire logic                    sysClk,
	input  wire logic                    rstN
);

	//--------------------------------------------------------------------
	// Address decode
	//--------------------------------------------------------------------
	logic [blockAdrsWidth-1:0] blkField;	// Upper field selects the block
	logic [csrOffsetWidth-1:0] csrOffset;	// Register within the block
	logic                      blkHit;
	logic                      wrHit;
	logic                      rdHit;

	assign blkField  = usiAdrs[busAdrsWidth-1 -: blockAdrsWidth];
	assign csrOffset = usiAdrs[csrOffsetWidth-1:0];
	assign blkHit    = (blkField == blockAdrs);
	assign wrHit     = usiWCke & blkHit;
	assign rdHit     = usiRCke & blkHit;	// Foreign reads never answer

	//--------------------------------------------------------------------
	// Control registers
	//--------------------------------------------------------------------
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			spiEn   <= 1'b0;
			spiDiv  <= '0;
			txByte  <= '0;
			csLevel <= 1'b0;	// Chip deselected out of reset
			txStart <= 1'b0;
		end
		else
		begin
			txStart <= 1'b0;	// Single cycle unless a tx write lands
			if (wrHit)
			begin
				case (csrOffset)
					csrEnOffset:
					begin
						spiEn <= usiWd[0];
					end
					csrDivOffset:
					begin
						spiDiv <= usiWd[divWidth-1:0];
					end
					csrTxOffset:
					begin
						txByte  <= usiWd[spiByteWidth-1:0];
						txStart <= 1'b1;	// Unit drops it if busy or disabled
					end
					csrCsOffset:
					begin
						csLevel <= usiWd[0];
					end
					default:
					begin
						// RO and unmapped offsets ignore writes
					end
				endcase
			end
		end
	end

	//--------------------------------------------------------------------
	// Read data
	//--------------------------------------------------------------------
	logic [busDataWidth-1:0] rdMux;

	always_comb
	begin
		rdMux = '0;	// Unmapped offsets read zero
		case (csrOffset)
			csrEnOffset:     rdMux[0]                = spiEn;
			csrDivOffset:    rdMux[divWidth-1:0]     = spiDiv;
			csrTxOffset:     rdMux[spiByteWidth-1:0] = txByte;
			csrCsOffset:     rdMux[0]                = csLevel;
			csrRxOffset:     rdMux[spiByteWidth-1:0] = rxByte;
			csrStatusOffset: rdMux[0]                = busy;
			default:         rdMux                   = '0;
		endcase
	end

	// Data and enable leave together, one cycle after the strobe
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			usiRd  <= '0;
			usiREd <= 1'b0;
		end
		else
		begin
			usiREd <= rdHit;
			if (rdHit)
			begin
				usiRd <= rdMux;
			end
		end
	end

endmodule

`default_nettype wire

/* source/spiMasterUnit.sv */
/*
 * SPI master unit, mode 0, MSB first
 * SCK divider, shift engine, receive latch and completion interrupt
 */
`timescale 1ns/10ps
`default_nettype none

module spiMasterUnit
	import spiCorePkg::*;
(
	// Control from the CSR block
	input  wire logic                    spiEn,
	input  wire logic [divWidth-1:0]     spiDiv,
	input  wire logic [spiByteWidth-1:0] txByte,
	input  wire logic                    csLevel,
	input  wire logic                    txStart,
	// Status back to the CSR block
	output      logic [spiByteWidth-1:0] rxByte,
	output      logic                    busy,
	// SPI pins
	output      logic                    spiSck,
	output      logic                    spiMosi,
	output      logic                    spiCs,
	input  wire logic                    spiMiso,
	// Interrupt
	output      logic                    spiIntr,
	// Clock and reset
	input  wire logic                    sysClk,
	input  wire logic                    rstN
);

	//--------------------------------------------------------------------
	// Internal state
	//--------------------------------------------------------------------
	logic [divWidth-1:0]      halfCnt;	// Cycles left in this half period
	logic [bitCountWidth-1:0] bitCnt;	// Bit index within the byte
	logic [spiByteWidth-1:0]  txShift;	// MSB drives MOSI
	logic [spiByteWidth-1:0]  rxShift;	// MISO shifts in at LSB
	logic                     startOk;
	logic                     halfDone;
	logic                     sckRise;
	logic                     sckFall;
	logic                     lastBit;

	assign startOk  = txStart & spiEn & ~busy;	// Busy check lives here only
	assign halfDone = busy & (halfCnt == '0);
	assign sckRise  = halfDone & ~spiSck;	// Sample edge
	assign sckFall  = halfDone & spiSck;	// Shift edge
	assign lastBit  = (bitCnt == {bitCountWidth{1'b1}});

	// Pin outputs
	assign spiMosi = txShift[spiByteWidth-1];
	assign spiCs   = ~csLevel;	// Straight from the register, active low

	//--------------------------------------------------------------------
	// Half-period timer and SCK
	//--------------------------------------------------------------------
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			halfCnt <= '0;
			spiSck  <= 1'b0;	// Mode 0 idles low
		end
		else if (startOk)
		begin
			halfCnt <= spiDiv;	// First half period starts now
			spiSck  <= 1'b0;
		end
		else if (halfDone)
		begin
			halfCnt <= spiDiv;
			spiSck  <= ~spiSck;
		end
		else if (busy)
		begin
			halfCnt <= halfCnt - 1'b1;
		end
	end

	//--------------------------------------------------------------------
	// Shift engine and bit counter
	//--------------------------------------------------------------------
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			busy    <= 1'b0;
			bitCnt  <= '0;
			txShift <= '0;
			rxShift <= '0;
		end
		else if (startOk)
		begin
			busy    <= 1'b1;
			bitCnt  <= '0;
			txShift <= txByte;	// MSB valid on the busy edge
		end
		else if (sckRise)
		begin
			rxShift <= {rxShift[spiByteWidth-2:0], spiMiso};
		end
		else if (sckFall)
		begin
			if (lastBit)
			begin
				busy <= 1'b0;	// 16th half period done
			end
			else
			begin
				bitCnt  <= bitCnt + 1'b1;
				txShift <= {txShift[spiByteWidth-2:0], 1'b0};	// Next bit out
			end
		end
	end

	//--------------------------------------------------------------------
	// Receive latch and interrupt
	//--------------------------------------------------------------------
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			rxByte  <= '0;
			spiIntr <= 1'b0;
		end
		else
		begin
			spiIntr <= sckFall & lastBit;	// One cycle, same edge busy drops
			if (sckFall && lastBit)
			begin
				rxByte <= rxShift;	// All eight bits sampled by now
			end
		end
	end

endmodule

`default_nettype wire

/* source/spiBlock.sv */
/*
 * SPI master block on the Usi register bus
 * Ties the CSR block to the master unit
 */
`timescale 1ns/10ps
`default_nettype none

module spiBlock
	import spiBusPkg::*;
	import spiCorePkg::*;
#(
	parameter int                        busAdrsWidth   = 16,
	parameter int                        blockAdrsWidth = 8,
	parameter logic [blockAdrsWidth-1:0] blockAdrs      = 8'h03
)(
	// Usi slave
	input  wire logic [busDataWidth-1:0] usiWd,
	input  wire logic [busAdrsWidth-1:0] usiAdrs,
	input  wire logic                    usiWCke,
	input  wire logic                    usiRCke,
	output wire logic [busDataWidth-1:0] usiRd,
	output wire logic                    usiREd,
	// SPI pins
	output wire logic                    spiSck,
	output wire logic                    spiMosi,
	output wire logic                    spiCs,
	input  wire logic                    spiMiso,
	// Interrupt
	output wire logic                    spiIntr,
	// Clock and reset
	input  wire logic                    sysClk,
	input  wire logic                    rstN
);

	//--------------------------------------------------------------------
	// CSR to unit
	//--------------------------------------------------------------------
	logic                    spiEn;
	logic [divWidth-1:0]     spiDiv;
	logic [spiByteWidth-1:0] txByte;
	logic                    csLevel;
	logic                    txStart;	// One-cycle kick
	logic [spiByteWidth-1:0] rxByte;	// Back to the CSR
	logic                    busy;

	spiCsr #(
		.busAdrsWidth   (busAdrsWidth),
		.blockAdrsWidth (blockAdrsWidth),
		.blockAdrs      (blockAdrs)
	) SPI_CSR (
		.usiWd   (usiWd),
		.usiAdrs (usiAdrs),
		.usiWCke (usiWCke),
		.usiRCke (usiRCke),
		.usiRd   (usiRd),
		.usiREd  (usiREd),
		.spiEn   (spiEn),
		.spiDiv  (spiDiv),
		.txByte  (txByte),
		.csLevel (csLevel),
		.txStart (txStart),
		.rxByte  (rxByte),
		.busy    (busy),
		.sysClk  (sysClk),
		.rstN    (rstN)
	);

	spiMasterUnit SPI_UNIT (
		.spiEn   (spiEn),
		.spiDiv  (spiDiv),
		.txByte  (txByte),
		.csLevel (csLevel),
		.txStart (txStart),
		.rxByte  (rxByte),
		.busy    (busy),
		.spiSck  (spiSck),
		.spiMosi (spiMosi),
		.spiCs   (spiCs),
		.spiMiso (spiMiso),
		.spiIntr (spiIntr),
		.sysClk  (sysClk),
		.rstN    (rstN)
	);

endmodule

`default_nettype wire

/* dv/spiSlaveModel.sv */
/*
 * Behavioral SPI slave, mode 0, MSB first
 * Answers with a preset byte and records the byte seen on MOSI
 */
`timescale 1ns/10ps
`default_nettype none

module spiSlaveModel (
	input  wire logic       sck,
	input  wire logic       mosi,
	input  wire logic       cs,	// Active low
	output wire logic       miso,
	input  wire logic [7:0] respByte,	// Taken when cs falls
	output wire logic [7:0] lastRx	// Last full byte received
);

	logic [7:0] respLatch = 8'h00;
	logic [7:0] rxShift   = 8'h00;
	logic [7:0] rxRecord  = 8'h00;
	int         fallCount = 0;	// Falling SCK edges since select
	int         riseCount = 0;	// Rising SCK edges since select

	assign lastRx = rxRecord;

	// Response byte latched at select
	always @(negedge cs)
	begin
		respLatch = respByte;
	end

	// MSB first, next bit after each falling edge
	assign miso = (fallCount < 8) ? respLatch[3'(7 - fallCount)] : 1'b0;

	always @(negedge sck or posedge cs)
	begin
		if (cs)
			fallCount = 0;	// Deselect rewinds the output bit
		else
			fallCount = fallCount + 1;
	end

	// MOSI sampled on rising SCK
	always @(posedge sck or posedge cs)
	begin
		if (cs)
		begin
			riseCount = 0;
		end
		else
		begin
			rxShift   = {rxShift[6:0], mosi};
			riseCount = riseCount + 1;
			if (riseCount == 8)
				rxRecord = rxShift;	// Whole byte in
		end
	end

endmodule

`default_nettype wire

/* dv/spiBlockTb.sv */
/*
 * Testbench for the SPI master block
 * Table-driven transfers against a slave model, plus CSR, gating
 * and address decode checks
 */
`timescale 1ns/10ps
`default_nettype none

module spiBlockTb
	import spiBusPkg::*;
();

	localparam int         clkPeriod   = 100;
	localparam int         drvDelay    = 1;	// Input skew after the edge
	localparam int         readWindow  = 8;	// Cycles allowed for usiREd
	localparam logic [7:0] blockAdrs   = 8'h03;
	localparam logic [7:0] foreignBlk  = 8'h05;
	localparam int         numTblRows  = 4;
	localparam int         numRandRows = 4;

	logic                    sysClk;
	logic                    rstN;
	logic [busDataWidth-1:0] usiWd;
	logic [15:0]             usiAdrs;
	logic                    usiWCke;
	logic                    usiRCke;
	wire  [busDataWidth-1:0] usiRd;
	wire                     usiREd;
	wire                     spiSck;
	wire                     spiMosi;
	wire                     spiCs;
	wire                     spiMiso;
	wire                     spiIntr;
	logic [7:0]              slvResp;	// Byte the slave answers with
	wire  [7:0]              slvLastRx;
	logic [31:0]             rngState;

	// Divider, tx byte, slave response
	logic [15:0] tblDiv  [numTblRows] = '{16'd0, 16'd1, 16'd2, 16'd4};
	logic [7:0]  tblTx   [numTblRows] = '{8'hA5, 8'h81, 8'h00, 8'hC3};
	logic [7:0]  tblResp [numTblRows] = '{8'h5A, 8'h7E, 8'hFF, 8'h96};

	spiBlock #(
		.busAdrsWidth   (16),
		.blockAdrsWidth (8),
		.blockAdrs      (blockAdrs)
	) UUT (
		.usiWd   (usiWd),
		.usiAdrs (usiAdrs),
		.usiWCke (usiWCke),
		.usiRCke (usiRCke),
		.usiRd   (usiRd),
		.usiREd  (usiREd),
		.spiSck  (spiSck),
		.spiMosi (spiMosi),
		.spiCs   (spiCs),
		.spiMiso (spiMiso),
		.spiIntr (spiIntr),
		.sysClk  (sysClk),
		.rstN    (rstN)
	);

	spiSlaveModel SLAVE (
		.sck      (spiSck),
		.mosi     (spiMosi),
		.cs       (spiCs),
		.miso     (spiMiso),
		.respByte (slvResp),
		.lastRx   (slvLastRx)
	);

	initial
	begin
		sysClk = 1'b0;
		forever #(clkPeriod/2) sysClk = ~sysClk;
	end

	//--------------------------------------------------------------------
	// Helpers
	//--------------------------------------------------------------------
	function automatic logic [31:0] nextRandom(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);	// xorshift32
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [15:0] csrAdrs(input logic [7:0] off);
		return {blockAdrs, off};
	endfunction

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic checkEq(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			abortRun($sformatf("MISMATCH at %0t: %s, got %h expected %h", $time, what, got, exp));
	endtask

	task automatic stepCycle();
		@(posedge sysClk);
		#drvDelay;
	endtask

	task automatic busWrite(input logic [15:0] adrs, input logic [31:0] data);
		usiAdrs = adrs;
		usiWd   = data;
		usiWCke = 1'b1;
		stepCycle();	// Taken on this edge
		usiWCke = 1'b0;
	endtask

	task automatic busRead(input logic [15:0] adrs, output logic [31:0] data);
		int waited;
		usiAdrs = adrs;
		usiRCke = 1'b1;
		stepCycle();
		usiRCke = 1'b0;
		waited  = 0;
		while (!usiREd)
		begin
			if (waited >= readWindow)
				abortRun("timed out waiting for usiREd on a block read");
			stepCycle();
			waited++;
		end
		data = usiRd;
		stepCycle();
		checkEq("usiREd single cycle", 32'(usiREd), 32'h0);
	endtask

	// Read that must stay unanswered
	task automatic expectNoRead(input logic [15:0] adrs);
		usiAdrs = adrs;
		usiRCke = 1'b1;
		stepCycle();
		usiRCke = 1'b0;
		for (int i = 0; i < readWindow; i++)
		begin
			if (usiREd)
				abortRun("usiREd answered a read outside the block");
			stepCycle();
		end
	endtask

	// No SCK activity and no interrupt for a whole window
	task automatic expectIdle(input int cycles);
		logic prevSck;
		prevSck = spiSck;
		for (int i = 0; i < cycles; i++)
		begin
			stepCycle();
			if (spiSck !== prevSck || spiIntr)
				abortRun("SPI activity seen while no transfer may run");
		end
	endtask

	// Wait for spiIntr, optionally timing each SCK half period
	task automatic waitIntr(input int div, input bit checkGaps);
		int   cyc;
		int   gap;
		int   edges;
		logic prevSck;
		cyc     = 0;
		gap     = 0;
		edges   = 0;
		prevSck = spiSck;
		while (!spiIntr)
		begin
			if (cyc >= 16 * (div + 1) + 16)
				abortRun("timed out waiting for spiIntr");
			stepCycle();
			cyc++;
			gap++;
			if (spiSck !== prevSck)
			begin
				if (checkGaps && edges > 0)
					checkEq("SCK half period in sysClk cycles", 32'(gap), 32'(div + 1));
				edges++;
				gap     = 0;
				prevSck = spiSck;
			end
		end
		if (checkGaps)
			checkEq("SCK edges per byte", 32'(edges), 32'd16);
	endtask

	// Select cycle, kick, then check both directions
	task automatic runTransfer(input logic [15:0] div, input logic [7:0] tx,
		input logic [7:0] resp);
		logic [31:0] rd;
		slvResp = resp;
		busWrite(csrAdrs(csrDivOffset), 32'(div));
		busWrite(csrAdrs(csrCsOffset), 32'h0);
		busWrite(csrAdrs(csrCsOffset), 32'h1);	// Slave loads resp here
		busWrite(csrAdrs(csrTxOffset), 32'(tx));
		waitIntr(int'(div), 1'b1);
		checkEq("slave received byte", 32'(slvLastRx), 32'(tx));
		busRead(csrAdrs(csrRxOffset), rd);
		checkEq("rx register", rd, 32'(resp));
		busRead(csrAdrs(csrStatusOffset), rd);
		checkEq("status after transfer", rd, 32'h0);
	endtask

	//--------------------------------------------------------------------
	// Main sequence
	//--------------------------------------------------------------------
	initial
	begin
		logic [31:0] rd;
		logic [31:0] saved;
		rngState = 32'hfe17;
		rstN     = 1'b0;
		usiWd    = '0;
		usiAdrs  = '0;
		usiWCke  = 1'b0;
		usiRCke  = 1'b0;
		slvResp  = 8'h00;
		repeat (5) @(posedge sysClk);
		#drvDelay;
		rstN = 1'b1;

		// Reset state
		checkEq("spiCs after reset", 32'(spiCs), 32'h1);
		checkEq("spiSck after reset", 32'(spiSck), 32'h0);
		checkEq("spiIntr after reset", 32'(spiIntr), 32'h0);
		busRead(csrAdrs(csrRxOffset), rd);
		checkEq("rx after reset", rd, 32'h0);
		busRead(csrAdrs(csrStatusOffset), rd);
		checkEq("status after reset", rd, 32'h0);

		// Register readback, divider keeps low 16 bits only
		busWrite(csrAdrs(csrEnOffset), 32'h1);
		busRead(csrAdrs(csrEnOffset), rd);
		checkEq("enable readback", rd, 32'h1);
		busWrite(csrAdrs(csrDivOffset), 32'hABCD_0005);
		busRead(csrAdrs(csrDivOffset), rd);
		checkEq("divider readback", rd, 32'h0000_0005);
		busWrite(csrAdrs(csrCsOffset), 32'h1);
		busRead(csrAdrs(csrCsOffset), rd);
		checkEq("chip select readback", rd, 32'h1);
		checkEq("spiCs pin when selected", 32'(spiCs), 32'h0);

		// Table rows, then random rows
		for (int r = 0; r < numTblRows; r++)
			runTransfer(tblDiv[r], tblTx[r], tblResp[r]);
		for (int r = 0; r < numRandRows; r++)
		begin
			rngState = nextRandom(rngState);
			runTransfer(16'(rngState[1:0]), rngState[15:8], rngState[23:16]);
		end

		// Disabled unit ignores a kick
		busWrite(csrAdrs(csrDivOffset), 32'h3);
		busWrite(csrAdrs(csrEnOffset), 32'h0);
		busRead(csrAdrs(csrRxOffset), saved);
		busWrite(csrAdrs(csrTxOffset), 32'h66);
		expectIdle(16 * 4 + 16);
		busRead(csrAdrs(csrRxOffset), rd);
		checkEq("rx unchanged while disabled", rd, saved);
		busWrite(csrAdrs(csrEnOffset), 32'h1);

		// Second kick while busy is dropped
		slvResp = 8'h42;
		busWrite(csrAdrs(csrCsOffset), 32'h0);
		busWrite(csrAdrs(csrCsOffset), 32'h1);
		busWrite(csrAdrs(csrTxOffset), 32'h3C);
		stepCycle();	// Busy rises one edge after txStart
		busRead(csrAdrs(csrStatusOffset), rd);
		checkEq("status busy mid transfer", rd, 32'h1);
		busWrite(csrAdrs(csrTxOffset), 32'hC3);
		waitIntr(3, 1'b0);
		checkEq("slave byte after dropped kick", 32'(slvLastRx), 32'h3C);
		busRead(csrAdrs(csrRxOffset), rd);
		checkEq("rx after dropped kick", rd, 32'h42);
		expectIdle(16 * 4 + 16);	// No follow-up transfer

		// Address decode
		expectNoRead({foreignBlk, csrDivOffset});
		busRead(csrAdrs(8'h18), rd);
		checkEq("unmapped offset 0x18", rd, 32'h0);
		busRead(csrAdrs(8'h20), rd);
		checkEq("unmapped offset 0x20", rd, 32'h0);
		busRead(csrAdrs(csrDivOffset), saved);
		busWrite({foreignBlk, csrDivOffset}, 32'h0777);
		busRead(csrAdrs(csrDivOffset), rd);
		checkEq("divider after foreign write", rd, saved);

		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
source/spiBusPkg.sv
source/spiCorePkg.sv
source/spiCsr.sv
source/spiMasterUnit.sv
source/spiBlock.sv
dv/spiSlaveModel.sv
dv/spiBlockTb.sv

/* Makefile */
# Verilator build and run of the SPI block testbench

VERILATOR = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = spiBlockTb
FILELIST  = sim.f
OBJDIR    = obj_dir

.PHONY: sim clean

# Pass only when the run prints the pass line
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(OBJDIR)
